/* rtl/rvc_pkg.sv */
package rvc_pkg;

  // base opcodes of the 32-bit expansion targets
  localparam logic [6:0] OP_IMM = 7'b0010011;
  localparam logic [6:0] OP     = 7'b0110011;
  localparam logic [6:0] LOAD   = 7'b0000011;
  localparam logic [6:0] STORE  = 7'b0100011;
  localparam logic [6:0] BRANCH = 7'b1100011;
  localparam logic [6:0] JAL    = 7'b1101111;
  localparam logic [6:0] JALR   = 7'b1100111;
  localparam logic [6:0] LUI    = 7'b0110111;

  // pc of the first fetch word, word aligned
  localparam logic [31:0] RESET_PC = 32'h8000_0000;

  // one fetch word, either a whole instruction or two parcels
  // half[0] sits at the lower address
  typedef union packed {
    logic [31:0]      full;
    logic [1:0][15:0] half;
  } fetch_word_t;

  // aligner to expander and output stage
  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] raw;
    logic        is_compressed;
  } raw_inst_t;

  // output stage toward the decoder
  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] inst;
    logic [31:0] raw;
    logic        is_compressed;
    logic        illegal;
  } dec_inst_t;

endpackage

/* rtl/rvc_expander.sv */
`timescale 1ns/1ns

module rvc_expander (
  input  logic [31:0] raw_parcel,
  output logic [31:0] inst,
  output logic        illegal
);

  logic [15:0] c;
  // compressed register fields map onto x8..x15
  logic [4:0]  reg_97;
  logic [4:0]  reg_42;
  // sign-extended 6-bit immediate from bits 12 and 6:2
  logic [11:0] simm6;

  assign c      = raw_parcel[15:0];
  assign reg_97 = {2'b01, c[9:7]};
  assign reg_42 = {2'b01, c[4:2]};
  assign simm6  = {{7{c[12]}}, c[6:2]};

  always_comb begin
    inst    = raw_parcel;
    illegal = 1'b0;

    case (c[1:0])
      // quadrant 0
      2'b00: begin
        case (c[15:13])
          3'b000: begin
            // c.addi4spn -> addi rd', x2, nzuimm
            inst = {2'b0, c[10:7], c[12:11], c[5], c[6], 2'b00, 5'd2, 3'b000, reg_42,
                    rvc_pkg::OP_IMM};
            illegal = (c[12:5] == 8'b0);
          end

          3'b010: begin
            // c.lw -> lw rd', uimm(rs1')
            inst = {5'b0, c[5], c[12:10], c[6], 2'b00, reg_97, 3'b010, reg_42, rvc_pkg::LOAD};
          end

          3'b100: begin
            // zcb byte and half loads and stores
            case (c[12:10])
              3'b000: begin
                // c.lbu
                inst = {10'b0, c[5], c[6], reg_97, 3'b100, reg_42, rvc_pkg::LOAD};
              end
              3'b001: begin
                // c.lh with bit 6 set, c.lhu without
                inst = {10'b0, c[5], 1'b0, reg_97, ~c[6], 2'b01, reg_42, rvc_pkg::LOAD};
              end
              3'b010: begin
                // c.sb
                inst = {7'b0, reg_42, reg_97, 3'b000, 3'b0, c[5], c[6], rvc_pkg::STORE};
              end
              3'b011: begin
                // c.sh, bit 6 set is a reserved slot
                inst    = {7'b0, reg_42, reg_97, 3'b001, 3'b0, c[5], 1'b0, rvc_pkg::STORE};
                illegal = c[6];
              end
              default: begin
                illegal = 1'b1;
              end
            endcase
          end

          3'b110: begin
            // c.sw -> sw rs2', uimm(rs1')
            inst = {5'b0, c[5], c[12], reg_42, reg_97, 3'b010, c[11:10], c[6], 2'b00,
                    rvc_pkg::STORE};
          end

          // floating point and reserved slots
          default: begin
            illegal = 1'b1;
          end
        endcase
      end

      // quadrant 1
      2'b01: begin
        case (c[15:13])
          3'b000: begin
            // c.addi and c.nop
            inst = {simm6, c[11:7], 3'b000, c[11:7], rvc_pkg::OP_IMM};
          end

          3'b001, 3'b101: begin
            // c.jal links x1, c.j links x0
            inst = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], {9{c[12]}},
                    4'b0, ~c[15], rvc_pkg::JAL};
          end

          3'b010: begin
            // c.li -> addi rd, x0, imm
            inst = {simm6, 5'b0, 3'b000, c[11:7], rvc_pkg::OP_IMM};
          end

          3'b011: begin
            if (c[11:7] == 5'd2) begin
              // c.addi16sp -> addi x2, x2, nzimm
              inst = {{3{c[12]}}, c[4:3], c[5], c[2], c[6], 4'b0, 5'd2, 3'b000, 5'd2,
                      rvc_pkg::OP_IMM};
            end else begin
              // c.lui -> lui rd, nzimm
              inst = {{15{c[12]}}, c[6:2], c[11:7], rvc_pkg::LUI};
            end
            illegal = ({c[12], c[6:2]} == 6'b0);
          end

          3'b100: begin
            case (c[11:10])
              2'b00, 2'b01: begin
                // c.srli and c.srai, shamt[5] must be clear on RV32
                inst = {1'b0, c[10], 5'b0, c[6:2], reg_97, 3'b101, reg_97, rvc_pkg::OP_IMM};
                illegal = c[12];
              end
              2'b10: begin
                // c.andi
                inst = {simm6, reg_97, 3'b111, reg_97, rvc_pkg::OP_IMM};
              end
              default: begin
                case ({c[12], c[6:5]})
                  3'b000: inst = {7'b0100000, reg_42, reg_97, 3'b000, reg_97, rvc_pkg::OP};
                  3'b001: inst = {7'b0000000, reg_42, reg_97, 3'b100, reg_97, rvc_pkg::OP};
                  3'b010: inst = {7'b0000000, reg_42, reg_97, 3'b110, reg_97, rvc_pkg::OP};
                  3'b011: inst = {7'b0000000, reg_42, reg_97, 3'b111, reg_97, rvc_pkg::OP};
                  3'b110: begin
                    // c.mul from zcb
                    inst = {7'b0000001, reg_42, reg_97, 3'b000, reg_97, rvc_pkg::OP};
                  end
                  3'b111: begin
                    // zcb unary ops, selected by bits 4:2
                    case (c[4:2])
                      3'b000: inst = {12'h0ff, reg_97, 3'b111, reg_97, rvc_pkg::OP_IMM};
                      3'b001: inst = {12'h604, reg_97, 3'b001, reg_97, rvc_pkg::OP_IMM};
                      3'b010: inst = {12'h080, reg_97, 3'b100, reg_97, rvc_pkg::OP};
                      3'b011: inst = {12'h605, reg_97, 3'b001, reg_97, rvc_pkg::OP_IMM};
                      3'b101: inst = {12'hfff, reg_97, 3'b100, reg_97, rvc_pkg::OP_IMM};
                      default: begin
                        // c.zext.w is RV64 only
                        illegal = 1'b1;
                      end
                    endcase
                  end
                  default: begin
                    // subw and addw slots
                    illegal = 1'b1;
                  end
                endcase
              end
            endcase
          end

          default: begin
            // c.beqz and c.bnez, funct3 follows bit 13
            inst = {{4{c[12]}}, c[6:5], c[2], 5'b0, reg_97, 2'b00, c[13], c[11:10], c[4:3],
                    c[12], rvc_pkg::BRANCH};
          end
        endcase
      end

      // quadrant 2
      2'b10: begin
        case (c[15:13])
          3'b000: begin
            // c.slli, bit 12 set is reserved on RV32
            inst    = {7'b0, c[6:2], c[11:7], 3'b001, c[11:7], rvc_pkg::OP_IMM};
            illegal = c[12];
          end

          3'b010: begin
            // c.lwsp -> lw rd, uimm(x2)
            inst = {4'b0, c[3:2], c[12], c[6:4], 2'b00, 5'd2, 3'b010, c[11:7], rvc_pkg::LOAD};
            illegal = (c[11:7] == 5'b0);
          end

          3'b100: begin
            if (c[6:2] != 5'b0) begin
              // c.mv adds to x0, c.add adds to rd
              inst = {7'b0, c[6:2], c[11:7] & {5{c[12]}}, 3'b000, c[11:7], rvc_pkg::OP};
            end else if (!c[12]) begin
              // c.jr, rs1 of x0 is reserved
              inst    = {12'b0, c[11:7], 3'b000, 5'b0, rvc_pkg::JALR};
              illegal = (c[11:7] == 5'b0);
            end else if (c[11:7] == 5'b0) begin
              // c.ebreak
              inst = 32'h0010_0073;
            end else begin
              // c.jalr links x1
              inst = {12'b0, c[11:7], 3'b000, 5'd1, rvc_pkg::JALR};
            end
          end

          3'b110: begin
            // c.swsp -> sw rs2, uimm(x2)
            inst = {4'b0, c[8:7], c[12], c[6:2], 5'd2, 3'b010, c[11:9], 2'b00, rvc_pkg::STORE};
          end

          default: begin
            illegal = 1'b1;
          end
        endcase
      end

      // full 32-bit instruction passes through untouched
      default: begin
        inst = raw_parcel;
      end
    endcase
  end

endmodule

/* rtl/fetch_aligner.sv */
`timescale 1ns/1ns

module fetch_aligner (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 fetch_valid,
  input  rvc_pkg::fetch_word_t fetch_word,
  input  logic                 cand_ready,
  output logic                 fetch_ready,
  output logic                 cand_valid,
  output rvc_pkg::raw_inst_t   cand
);

  rvc_pkg::fetch_word_t word_q;
  logic                 word_valid_q;
  logic                 idx_q;
  logic [15:0]          hold_q;
  logic                 hold_valid_q;
  logic [31:0]          pc_q;

  logic [15:0] parcel;
  logic        parcel_full;
  logic        straddle;
  logic        last_use;
  logic        fetch_fire;
  logic        cand_fire;

  assign parcel      = word_q.half[idx_q];
  assign parcel_full = (parcel[1:0] == 2'b11);

  // upper parcel opens a 32-bit instruction, park it until the next word
  assign straddle = word_valid_q && !hold_valid_q && idx_q && parcel_full;

  always_comb begin
    cand_valid         = 1'b0;
    cand.pc            = pc_q;
    cand.raw           = {16'b0, parcel};
    cand.is_compressed = 1'b1;
    if (hold_valid_q) begin
      // saved upper parcel is the low half of the instruction
      cand_valid         = word_valid_q;
      cand.raw           = {word_q.half[0], hold_q};
      cand.is_compressed = 1'b0;
    end else if (word_valid_q) begin
      if (!parcel_full) begin
        cand_valid = 1'b1;
      end else if (!idx_q) begin
        cand_valid         = 1'b1;
        cand.raw           = word_q.full;
        cand.is_compressed = 1'b0;
      end
    end
  end

  assign cand_fire  = cand_valid && cand_ready;
  // this candidate takes the last parcel of the held word
  assign last_use   = cand_fire && !hold_valid_q && (idx_q || parcel_full);
  assign fetch_ready = !word_valid_q || straddle || last_use;
  assign fetch_fire = fetch_valid && fetch_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      word_valid_q <= 1'b0;
      idx_q        <= 1'b0;
      hold_valid_q <= 1'b0;
      pc_q         <= rvc_pkg::RESET_PC;
    end else begin
      if (cand_fire) begin
        pc_q         <= pc_q + (cand.is_compressed ? 32'd2 : 32'd4);
        hold_valid_q <= 1'b0;
        idx_q        <= 1'b1;
        if (last_use) begin
          word_valid_q <= 1'b0;
        end
      end
      if (fetch_fire) begin
        word_valid_q <= 1'b1;
        idx_q        <= 1'b0;
        if (straddle) begin
          hold_valid_q <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_fire) begin
      word_q <= fetch_word;
      if (straddle) begin
        hold_q <= word_q.half[1];
      end
    end
  end

endmodule

/* rtl/inst_out_stage.sv */
`timescale 1ns/1ns

module inst_out_stage (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               cand_valid,
  input  rvc_pkg::raw_inst_t cand,
  input  logic [31:0]        exp_inst,
  input  logic               exp_illegal,
  input  logic               out_ready,
  output logic               cand_ready,
  output logic               out_valid,
  output rvc_pkg::dec_inst_t out_inst
);

  logic cand_fire;

  // accept when empty or when the held item leaves this cycle
  assign cand_ready = !out_valid || out_ready;
  assign cand_fire  = cand_valid && cand_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (cand_fire) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (cand_fire) begin
      out_inst.pc            <= cand.pc;
      out_inst.inst          <= exp_inst;
      out_inst.raw           <= cand.raw;
      out_inst.is_compressed <= cand.is_compressed;
      // full instructions are checked later by the decoder
      out_inst.illegal       <= cand.is_compressed && exp_illegal;
    end
  end

endmodule

/* rtl/rvc_frontend.sv */
`timescale 1ns/1ns

module rvc_frontend (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 fetch_valid,
  input  rvc_pkg::fetch_word_t fetch_word,
  input  logic                 out_ready,
  output logic                 fetch_ready,
  output logic                 out_valid,
  output rvc_pkg::dec_inst_t   out_inst
);

  logic               cand_valid;
  logic               cand_ready;
  rvc_pkg::raw_inst_t cand;
  logic [31:0]        exp_inst;
  logic               exp_illegal;

  fetch_aligner u_aligner (
    .clk        (clk),
    .rst_n      (rst_n),
    .fetch_valid(fetch_valid),
    .fetch_word (fetch_word),
    .cand_ready (cand_ready),
    .fetch_ready(fetch_ready),
    .cand_valid (cand_valid),
    .cand       (cand)
  );

  // expansion happens in the same cycle the candidate is offered
  rvc_expander u_expander (
    .raw_parcel(cand.raw),
    .inst      (exp_inst),
    .illegal   (exp_illegal)
  );

  inst_out_stage u_out_stage (
    .clk        (clk),
    .rst_n      (rst_n),
    .cand_valid (cand_valid),
    .cand       (cand),
    .exp_inst   (exp_inst),
    .exp_illegal(exp_illegal),
    .out_ready  (out_ready),
    .cand_ready (cand_ready),
    .out_valid  (out_valid),
    .out_inst   (out_inst)
  );

endmodule

/* verif/rvc_ref_model.svh */
`ifndef RVC_REF_MODEL_SVH
`define RVC_REF_MODEL_SVH

// one instruction of the stimulus stream with its expected expansion
typedef struct packed {
  logic [31:0] raw;
  logic [31:0] inst;
  logic        illegal;
  logic [2:0]  size;
} stream_entry_t;

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] op);
  return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd);
  return {f7, rs2, rs1, f3, rd, rvc_pkg::OP};
endfunction

// sw only, the store width is fixed here
function automatic logic [31:0] enc_sw(input logic [11:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1);
  return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rvc_pkg::STORE};
endfunction

// kinds 0..11 are legal forms, 12..14 are illegal encodings
function automatic stream_entry_t make_compressed(input int kind, input logic [31:0] rnd);
  stream_entry_t e;
  logic [2:0]  rp;
  logic [2:0]  rq;
  logic [4:0]  rd;
  logic [4:0]  rs2;
  logic [5:0]  imm6;
  logic [9:0]  u;
  logic [15:0] c;
  logic [11:0] simm;
  rp   = rnd[31:29];
  rq   = rnd[28:26];
  rd   = rnd[25:21];
  rs2  = rnd[20:16];
  imm6 = rnd[15:10];
  // word-scaled offset, callers pick the bits their form can hold
  u    = {rnd[9:2], 2'b00};
  simm = {{6{imm6[5]}}, imm6};
  e.illegal = 1'b0;
  e.size    = 3'd2;
  e.inst    = 32'h0;
  case (kind)
    0: begin
      // c.addi4spn
      if (u[9:2] == 8'b0) u[2] = 1'b1;
      c = {3'b000, u[5:4], u[9:6], u[2], u[3], rp, 2'b00};
      e.inst = enc_i({2'b0, u}, 5'd2, 3'b000, {2'b01, rp}, rvc_pkg::OP_IMM);
    end
    1: begin
      // c.lw
      c = {3'b010, u[5:3], rq, u[2], u[6], rp, 2'b00};
      e.inst = enc_i({5'b0, u[6:0]}, {2'b01, rq}, 3'b010, {2'b01, rp}, rvc_pkg::LOAD);
    end
    2: begin
      // c.addi
      c = {3'b000, imm6[5], rd, imm6[4:0], 2'b01};
      e.inst = enc_i(simm, rd, 3'b000, rd, rvc_pkg::OP_IMM);
    end
    3: begin
      // c.li
      c = {3'b010, imm6[5], rd, imm6[4:0], 2'b01};
      e.inst = enc_i(simm, 5'd0, 3'b000, rd, rvc_pkg::OP_IMM);
    end
    4: begin
      // c.and
      c = {6'b100011, rp, 2'b11, rq, 2'b01};
      e.inst = enc_r(7'b0, {2'b01, rq}, {2'b01, rp}, 3'b111, {2'b01, rp});
    end
    5: begin
      // c.lwsp
      if (rd == 5'd0) rd = 5'd1;
      c = {3'b010, u[5], rd, u[4:2], u[7:6], 2'b10};
      e.inst = enc_i({4'b0, u[7:0]}, 5'd2, 3'b010, rd, rvc_pkg::LOAD);
    end
    6: begin
      // c.add
      if (rs2 == 5'd0) rs2 = 5'd1;
      c = {4'b1001, rd, rs2, 2'b10};
      e.inst = enc_r(7'b0, rs2, rd, 3'b000, rd);
    end
    7: begin
      // c.mv
      if (rs2 == 5'd0) rs2 = 5'd1;
      c = {4'b1000, rd, rs2, 2'b10};
      e.inst = enc_r(7'b0, rs2, 5'd0, 3'b000, rd);
    end
    8: begin
      // c.swsp
      c = {3'b110, u[5:2], u[7:6], rs2, 2'b10};
      e.inst = enc_sw({4'b0, u[7:0]}, rs2, 5'd2);
    end
    9: begin
      // c.lbu, byte offset 0..3
      c = {6'b100000, rq, u[2], u[3], rp, 2'b00};
      e.inst = enc_i({10'b0, u[3:2]}, {2'b01, rq}, 3'b100, {2'b01, rp}, rvc_pkg::LOAD);
    end
    10: begin
      // c.mul
      c = {6'b100111, rp, 2'b10, rq, 2'b01};
      e.inst = enc_r(7'b0000001, {2'b01, rq}, {2'b01, rp}, 3'b000, {2'b01, rp});
    end
    11: begin
      // c.not is xori with all ones
      c = {6'b100111, rp, 2'b11, 3'b101, 2'b01};
      e.inst = enc_i(12'hfff, {2'b01, rp}, 3'b100, {2'b01, rp}, rvc_pkg::OP_IMM);
    end
    12: begin
      // c.addi4spn with zero immediate
      c = {11'b0, rp, 2'b00};
      e.illegal = 1'b1;
    end
    13: begin
      // c.lwsp into x0
      c = {3'b010, u[5], 5'd0, u[4:2], u[7:6], 2'b10};
      e.illegal = 1'b1;
    end
    default: begin
      // quadrant 0 funct 100 with bit 12 set has no zcb meaning
      c = {4'b1001, rnd[1:0], rq, u[3:2], rp, 2'b00};
      e.illegal = 1'b1;
    end
  endcase
  e.raw = {16'b0, c};
  return e;
endfunction

function automatic stream_entry_t make_full(input logic [31:0] rnd);
  stream_entry_t e;
  e.raw     = {rnd[31:2], 2'b11};
  e.inst    = e.raw;
  e.illegal = 1'b0;
  e.size    = 3'd4;
  return e;
endfunction

`endif

/* verif/tb_rvc_frontend.sv */
`timescale 1ns/1ns

module tb_rvc_frontend;

  localparam int WAIT_LIMIT = 200;

  logic                 clk = 1'b0;
  logic                 rst_n;
  logic                 fetch_valid;
  rvc_pkg::fetch_word_t fetch_word;
  logic                 out_ready;
  logic                 fetch_ready;
  logic                 out_valid;
  rvc_pkg::dec_inst_t   out_inst;

  logic [31:0]        stim_seed;
  logic               stall_mode;
  logic               gap_mode;
  string              test_name;
  int                 error_count;
  int                 check_count;
  int                 timeout_count;
  logic [31:0]        next_pc;
  rvc_pkg::dec_inst_t expect_q[$];
  logic [15:0]        parcel_q[$];
  rvc_pkg::dec_inst_t held_inst;
  logic               held_stall = 1'b0;

  `include "rvc_ref_model.svh"

  rvc_frontend UUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .fetch_valid(fetch_valid),
    .fetch_word (fetch_word),
    .out_ready  (out_ready),
    .fetch_ready(fetch_ready),
    .out_valid  (out_valid),
    .out_inst   (out_inst)
  );

  always #50 clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] rand_word();
    stim_seed = lcg_next(stim_seed);
    return stim_seed;
  endfunction

  // expected output record for one stream entry at a given pc
  function automatic rvc_pkg::dec_inst_t expected_output(input stream_entry_t e,
                                                         input logic [31:0] pc);
    rvc_pkg::dec_inst_t d;
    d.pc            = pc;
    d.inst          = e.inst;
    d.raw           = e.raw;
    d.is_compressed = (e.size == 3'd2);
    d.illegal       = e.illegal;
    return d;
  endfunction

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    if (expected !== actual) begin
      error_count++;
      $display("mismatch %s %s expected %h actual %h", test_name, what, expected, actual);
    end
  endtask

  task automatic compare_output(input rvc_pkg::dec_inst_t exp, input rvc_pkg::dec_inst_t act);
    check_value("pc", exp.pc, act.pc);
    check_value("raw", exp.raw, act.raw);
    check_value("compressed", {31'b0, exp.is_compressed}, {31'b0, act.is_compressed});
    check_value("illegal", {31'b0, exp.illegal}, {31'b0, act.illegal});
    // an illegal parcel has no defined expansion
    if (!exp.illegal) begin
      check_value("inst", exp.inst, act.inst);
    end
  endtask

  task automatic finish_run();
    $display("errors: %0d  timeouts: %0d  checks: %0d", error_count, timeout_count,
             check_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  endtask

  task automatic add_entry(input stream_entry_t e);
    expect_q.push_back(expected_output(e, next_pc));
    parcel_q.push_back(e.raw[15:0]);
    if (e.size == 3'd4) begin
      parcel_q.push_back(e.raw[31:16]);
    end
    next_pc = next_pc + {29'b0, e.size};
  endtask

  task automatic drive_words();
    rvc_pkg::fetch_word_t w;
    int                   wait_cycles;
    int                   gap;
    logic                 taken;
    // an odd parcel count is closed with c.li x0, 0
    if (parcel_q.size() % 2 != 0) begin
      add_entry(make_compressed(3, 32'h0));
    end
    while (parcel_q.size() > 0 && timeout_count == 0) begin
      if (gap_mode) begin
        gap = int'(rand_word() >> 30);
        repeat (gap) begin
          @(posedge clk);
          #10;
        end
      end
      w.half[0]   = parcel_q.pop_front();
      w.half[1]   = parcel_q.pop_front();
      fetch_valid = 1'b1;
      fetch_word  = w;
      wait_cycles = 0;
      taken       = 1'b0;
      while (!taken && wait_cycles < WAIT_LIMIT) begin
        @(negedge clk);
        taken = fetch_ready;
        @(posedge clk);
        #10;
        wait_cycles++;
      end
      fetch_valid = 1'b0;
      if (!taken) begin
        $display("timeout in %s: fetch word %h was never accepted", test_name, w.full);
        timeout_count++;
      end
    end
  endtask

  task automatic wait_drain();
    int wait_cycles;
    wait_cycles = 0;
    while (timeout_count == 0 && expect_q.size() > 0 && wait_cycles < WAIT_LIMIT) begin
      @(posedge clk);
      #10;
      wait_cycles++;
    end
    if (timeout_count == 0 && expect_q.size() > 0) begin
      $display("timeout in %s: %0d instructions never came out", test_name, expect_q.size());
      timeout_count++;
    end
  endtask

  // out_ready goes low at random while stall_mode is set
  initial begin
    logic [31:0] ready_seed;
    ready_seed = 32'd39;
    out_ready  = 1'b1;
    forever begin
      @(posedge clk);
      #10;
      if (stall_mode) begin
        ready_seed = lcg_next(ready_seed);
        out_ready  = (ready_seed[31:30] != 2'b00);
      end else begin
        out_ready = 1'b1;
      end
    end
  end

  // outputs are sampled mid cycle and a handshake seen here completes on the next rising edge
  always @(negedge clk) begin
    if (rst_n) begin
      if (held_stall) begin
        check_value("hold valid", 32'd1, {31'b0, out_valid});
        check_value("hold pc", held_inst.pc, out_inst.pc);
        check_value("hold inst", held_inst.inst, out_inst.inst);
        check_value("hold raw", held_inst.raw, out_inst.raw);
        check_value("hold flags", {30'b0, held_inst.is_compressed, held_inst.illegal},
                    {30'b0, out_inst.is_compressed, out_inst.illegal});
      end
      if (out_valid && out_ready) begin
        if (expect_q.size() == 0) begin
          error_count++;
          $display("unexpected instruction at pc %h with nothing left to expect", out_inst.pc);
        end else begin
          compare_output(expect_q.pop_front(), out_inst);
        end
      end
      held_stall = out_valid && !out_ready;
      held_inst  = out_inst;
    end
  end

  initial begin
    logic [31:0] r;
    int          i;
    rst_n         = 1'b0;
    fetch_valid   = 1'b0;
    fetch_word    = '0;
    stall_mode    = 1'b0;
    gap_mode      = 1'b0;
    stim_seed     = 32'd39;
    error_count   = 0;
    check_count   = 0;
    timeout_count = 0;
    next_pc       = rvc_pkg::RESET_PC;
    test_name     = "reset";
    repeat (5) @(posedge clk);
    #10;
    // empty front end after reset
    check_value("fetch_ready", 32'd1, {31'b0, fetch_ready});
    check_value("out_valid", 32'd0, {31'b0, out_valid});
    rst_n = 1'b1;

    test_name = "full_only";
    for (i = 0; i < 12; i++) begin
      add_entry(make_full(rand_word()));
    end
    drive_words();
    wait_drain();

    // each legal form twice so that both copies share one word
    test_name = "compressed";
    for (i = 0; i < 24; i++) begin
      add_entry(make_compressed(i / 2, rand_word()));
    end
    drive_words();
    wait_drain();

    // second entry starts in the upper parcel and straddles
    test_name = "mixed";
    add_entry(make_compressed(2, rand_word()));
    add_entry(make_full(rand_word()));
    for (i = 0; i < 24; i++) begin
      r = rand_word();
      if (r[31]) begin
        add_entry(make_full(rand_word()));
      end else begin
        add_entry(make_compressed(int'(r[30:27]) % 12, rand_word()));
      end
    end
    drive_words();
    wait_drain();

    test_name = "illegal";
    for (i = 0; i < 9; i++) begin
      add_entry(make_compressed(12 + i % 3, rand_word()));
    end
    drive_words();
    wait_drain();

    test_name  = "stress";
    stall_mode = 1'b1;
    gap_mode   = 1'b1;
    for (i = 0; i < 60; i++) begin
      r = rand_word();
      if (r[31]) begin
        add_entry(make_full(rand_word()));
      end else begin
        add_entry(make_compressed(int'(r[30:27]) % 15, rand_word()));
      end
    end
    drive_words();
    wait_drain();
    stall_mode = 1'b0;
    gap_mode   = 1'b0;

    finish_run();
  end

endmodule

/* files.f */
+incdir+verif
rtl/rvc_pkg.sv
rtl/rvc_expander.sv
rtl/fetch_aligner.sv
rtl/inst_out_stage.sv
rtl/rvc_frontend.sv
verif/tb_rvc_frontend.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f files.f --top-module tb_rvc_frontend -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "ERRORS FOUND" sim.log; then
  exit 1
fi
exit 0
